/* source/game_rom.sv */
`timescale 1ns/1ns

module game_rom #(
    parameter logic [rom_pkg::sdram_aw-1:0] snd_offset  = 22'h0A000,
    parameter logic [rom_pkg::sdram_aw-1:0] char_offset = 22'h0C000,
    parameter logic [rom_pkg::sdram_aw-1:0] prom_start  = 22'h1A000,
    parameter int                           main_aw     = 17,
    parameter int                           snd_aw      = 15,
    parameter int                           char_aw     = 12
) (
    input  logic                         clk,
    input  logic                         reset,
    // ROM download
    input  logic                         downloading,
    input  logic                         ioctl_wr,
    input  logic [rom_pkg::sdram_aw-1:0] ioctl_addr,
    input  logic [7:0]                   ioctl_data,
    output logic [rom_pkg::sdram_aw-1:0] prog_addr,
    output logic [7:0]                   prog_data,
    output logic [1:0]                   prog_mask,
    output logic                         prog_we,
    output logic [3:0]                   prom_we,
    // Game clients
    input  logic                         main_cs,
    input  logic [main_aw-1:0]           main_addr,
    output logic [7:0]                   main_dout,
    output logic                         main_ok,
    input  logic                         snd_cs,
    input  logic [snd_aw-1:0]            snd_addr,
    output logic [7:0]                   snd_dout,
    output logic                         snd_ok,
    input  logic                         char_cs,
    input  logic [char_aw-1:0]           char_addr,
    output logic [15:0]                  char_dout,
    output logic                         char_ok,
    // SDRAM
    output logic                         sdram_req,
    output logic [rom_pkg::sdram_aw-1:0] sdram_addr,
    input  logic                         sdram_ack,
    input  logic                         data_rdy,
    input  logic [rom_pkg::sdram_dw-1:0] data_read,
    output logic                         rom_ready
);

    localparam int main_ww = main_aw - 2;   // Byte clients drop two bits
    localparam int snd_ww  = snd_aw - 2;
    localparam int char_ww = char_aw - 1;   // Halfword client drops one
    localparam int xw      = rom_pkg::sdram_aw - 1;

    logic [main_ww-1:0] main_word;
    logic [snd_ww-1:0]  snd_word;
    logic [char_ww-1:0] char_word;
    logic               main_req, snd_req, char_req;
    logic               grant_main, grant_snd, grant_char;

    prom_loader #(.prom_start(prom_start)) u_loader (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    rom_arbiter #(
        .snd_offset  ( snd_offset  ),
        .char_offset ( char_offset )
    ) u_arbiter (
        .clk         ( clk                                 ),
        .reset       ( reset                               ),
        .downloading ( downloading                         ),
        .main_req    ( main_req                            ),
        .snd_req     ( snd_req                             ),
        .char_req    ( char_req                            ),
        .main_word   ( {{(xw-main_ww){1'b0}}, main_word}   ),
        .snd_word    ( {{(xw-snd_ww){1'b0}}, snd_word}     ),
        .char_word   ( {{(xw-char_ww){1'b0}}, char_word}   ),
        .sdram_ack   ( sdram_ack                           ),
        .data_rdy    ( data_rdy                            ),
        .sdram_req   ( sdram_req                           ),
        .sdram_addr  ( sdram_addr                          ),
        .grant_main  ( grant_main                          ),
        .grant_snd   ( grant_snd                           ),
        .grant_char  ( grant_char                          ),
        .rom_ready   ( rom_ready                           )
    );

    // data_read fans out, only the granted slot keeps it
    rom_slot #(.aw(main_aw), .dw(8)) u_main (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .cs          ( main_cs     ),
        .addr        ( main_addr   ),
        .grant       ( grant_main  ),
        .data_read   ( data_read   ),
        .dout        ( main_dout   ),
        .ok          ( main_ok     ),
        .req         ( main_req    ),
        .word_addr   ( main_word   )
    );

    rom_slot #(.aw(snd_aw), .dw(8)) u_snd (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .cs          ( snd_cs      ),
        .addr        ( snd_addr    ),
        .grant       ( grant_snd   ),
        .data_read   ( data_read   ),
        .dout        ( snd_dout    ),
        .ok          ( snd_ok      ),
        .req         ( snd_req     ),
        .word_addr   ( snd_word    )
    );

    rom_slot #(.aw(char_aw), .dw(16)) u_char (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .cs          ( char_cs     ),
        .addr        ( char_addr   ),
        .grant       ( grant_char  ),
        .data_read   ( data_read   ),
        .dout        ( char_dout   ),
        .ok          ( char_ok     ),
        .req         ( char_req    ),
        .word_addr   ( char_word   )
    );

endmodule

/* source/prom_loader.sv */
`timescale 1ns/1ns

module prom_loader #(
    parameter logic [rom_pkg::sdram_aw-1:0] prom_start = 22'h1A000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         downloading,
    input  logic                         ioctl_wr,
    input  logic [rom_pkg::sdram_aw-1:0] ioctl_addr,
    input  logic [7:0]                   ioctl_data,
    output logic [rom_pkg::sdram_aw-1:0] prog_addr,
    output logic [7:0]                   prog_data,
    output logic [1:0]                   prog_mask,
    output logic                         prog_we,
    output logic [3:0]                   prom_we
);

    logic                         wr_en;
    logic                         is_prom;
    logic [rom_pkg::sdram_aw-1:0] prom_off;

    // Host writes only count during a download
    assign wr_en    = downloading && ioctl_wr;
    assign is_prom  = ioctl_addr >= prom_start;
    assign prom_off = ioctl_addr - prom_start;  // Byte offset inside the PROM area

    // Write strobes, one cycle after the host write
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= 4'd0;
        end else begin
            prog_we <= wr_en && !is_prom;
            prom_we <= 4'd0;
            if (wr_en && is_prom) begin
                // 256 bytes per PROM, nothing fires past the last one
                prom_we <= 4'b0001 << prom_off[rom_pkg::sdram_aw-1:8];
            end
        end
    end

    // Address, data and byte lane follow the same write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            prog_data <= ioctl_data;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;    // Lane from byte parity
            if (is_prom) begin
                // PROMs take their address from the low bits
                prog_addr <= prom_off;
            end else begin
                prog_addr <= {1'b0, ioctl_addr[rom_pkg::sdram_aw-1:1]};    // Word address
            end
        end
    end

endmodule

/* source/rom_arbiter.sv */
`timescale 1ns/1ns

module rom_arbiter #(
    parameter logic [rom_pkg::sdram_aw-1:0] snd_offset  = 22'h0A000,
    parameter logic [rom_pkg::sdram_aw-1:0] char_offset = 22'h0C000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         downloading,
    input  logic                         main_req,
    input  logic                         snd_req,
    input  logic                         char_req,
    input  logic [rom_pkg::sdram_aw-2:0] main_word,    // 32-bit word index
    input  logic [rom_pkg::sdram_aw-2:0] snd_word,
    input  logic [rom_pkg::sdram_aw-2:0] char_word,
    input  logic                         sdram_ack,
    input  logic                         data_rdy,
    output logic                         sdram_req,
    output logic [rom_pkg::sdram_aw-1:0] sdram_addr,
    output logic                         grant_main,
    output logic                         grant_snd,
    output logic                         grant_char,
    output logic                         rom_ready
);

    rom_pkg::arb_state_e          state;
    rom_pkg::rom_region_e         region;        // Owner of the access in flight
    rom_pkg::rom_region_e         pick;
    logic [rom_pkg::sdram_aw-2:0] pick_word;
    logic [rom_pkg::sdram_aw-1:0] pick_offset;
    logic                         any_req;
    logic                         dwnld_l;
    logic                         served;

    assign any_req = main_req || snd_req || char_req;

    // Fixed priority, main CPU first
    always_comb begin
        pick      = rom_pkg::region_main;
        pick_word = main_word;
        if (!main_req && snd_req) begin
            pick      = rom_pkg::region_snd;
            pick_word = snd_word;
        end else if (!main_req && !snd_req && char_req) begin
            pick      = rom_pkg::region_char;
            pick_word = char_word;
        end
    end

    always_comb begin
        case (pick)
            rom_pkg::region_snd:  pick_offset = snd_offset;
            rom_pkg::region_char: pick_offset = char_offset;
            default:              pick_offset = '0;     // Main ROM sits at the bottom
        endcase
    end

    // One SDRAM access at a time
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= rom_pkg::arb_idle;
            region    <= rom_pkg::region_main;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                rom_pkg::arb_idle: begin
                    if (any_req && rom_ready && !downloading) begin
                        region     <= pick;
                        // SDRAM counts 16-bit words, two per client word
                        sdram_addr <= pick_offset + {pick_word, 1'b0};
                        sdram_req  <= 1'b1;
                        state      <= rom_pkg::arb_wait_ack;
                    end
                end
                rom_pkg::arb_wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= rom_pkg::arb_wait_data;
                    end
                end
                rom_pkg::arb_wait_data: begin
                    if (data_rdy) state <= rom_pkg::arb_idle;
                end
                default: begin
                    sdram_req <= 1'b0;
                    state     <= rom_pkg::arb_idle;
                end
            endcase
        end
    end

    // Grant rides on data_rdy so the slot captures data_read directly
    assign served     = (state == rom_pkg::arb_wait_data) && data_rdy;
    assign grant_main = served && (region == rom_pkg::region_main);
    assign grant_snd  = served && (region == rom_pkg::region_snd);
    assign grant_char = served && (region == rom_pkg::region_char);

    // ROM contents usable from the cycle after the download ends
    always_ff @(posedge clk) begin
        if (reset) begin
            dwnld_l   <= 1'b0;
            rom_ready <= 1'b0;
        end else begin
            dwnld_l <= downloading;
            if (downloading) begin
                rom_ready <= 1'b0;
            end else if (dwnld_l) begin
                rom_ready <= 1'b1;  // Falling edge of downloading
            end
        end
    end

endmodule

/* source/rom_pkg.sv */
package rom_pkg;

    // SDRAM geometry
    localparam int sdram_aw = 22;   // Address counts 16-bit words
    localparam int sdram_dw = 32;   // One read returns two consecutive words

    // Who asked for the access in flight
    typedef enum logic [1:0] {
        region_main,
        region_snd,
        region_char
    } rom_region_e;

    // SDRAM access sequence
    typedef enum logic [1:0] {
        arb_idle,       // Waiting for a slot to miss
        arb_wait_ack,   // Request held until the controller takes it
        arb_wait_data   // Waiting for data_rdy
    } arb_state_e;

endpackage

/* source/rom_slot.sv */
`timescale 1ns/1ns

module rom_slot #(
    parameter int  aw = 12,                  // Client address width
    parameter int  dw = 16,                  // Client data width, 8 or 16
    localparam int sw = (dw == 8) ? 2 : 1    // Lane select bits inside a 32-bit word
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         downloading,
    input  logic                         cs,
    input  logic [aw-1:0]                addr,
    input  logic                         grant,
    input  logic [rom_pkg::sdram_dw-1:0] data_read,
    output logic [dw-1:0]                dout,
    output logic                         ok,
    output logic                         req,
    output logic [aw-sw-1:0]             word_addr
);

    logic [rom_pkg::sdram_dw-1:0] cached;      // Last word fetched
    logic [aw-sw-1:0]             cached_addr;
    logic                         valid;
    logic                         hit;

    assign word_addr = addr[aw-1:sw];
    assign hit       = valid && (cached_addr == word_addr);

    // Client side
    assign ok   = cs && hit;
    assign dout = cached[addr[sw-1:0]*dw +: dw];    // Lowest address in the low lane

    // Miss goes to the arbiter, held until the grant fills the slot
    assign req = cs && !hit && !downloading;

    // Contents are stale once new ROM data comes in
    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            valid <= 1'b0;
        end else if (grant) begin
            valid <= 1'b1;
        end
    end

    // Grant and data arrive in the same cycle
    always_ff @(posedge clk) begin
        if (grant && !downloading) begin
            cached      <= data_read;
            cached_addr <= word_addr;   // Client holds addr until ok
        end
    end

endmodule

/* testbench/game_rom_tb.sv */
`timescale 1ns/1ns

module game_rom_tb;

    localparam logic [21:0] snd_offset  = 22'h0A000;
    localparam logic [21:0] char_offset = 22'h0C000;
    localparam logic [21:0] prom_start  = 22'h1A000;
    localparam int          snd_base    = 2 * snd_offset;   // Byte addresses in the download
    localparam int          char_base   = 2 * char_offset;

    // One row is either a download byte or a set of client reads
    typedef struct packed {
        logic        read;
        logic        hit;           // Must come from the cached word
        logic [2:0]  clients;       // One bit per client with main in bit 0
        logic [21:0] addr;
        logic [7:0]  data;
        logic [16:0] main_addr;
        logic [14:0] snd_addr;
        logic [11:0] char_addr;
        logic [7:0]  main_exp;
        logic [7:0]  snd_exp;
        logic [15:0] char_exp;
    } step_t;

    logic        clk, reset, downloading, ioctl_wr;
    logic [21:0] ioctl_addr, prog_addr, sdram_addr;
    logic [7:0]  ioctl_data, prog_data, main_dout, snd_dout;
    logic [1:0]  prog_mask;
    logic        prog_we, sdram_req, sdram_ack, data_rdy, rom_ready;
    logic [3:0]  prom_we;
    logic        main_cs, snd_cs, char_cs, main_ok, snd_ok, char_ok;
    logic [16:0] main_addr;
    logic [14:0] snd_addr;
    logic [11:0] char_addr;
    logic [15:0] char_dout;
    logic [31:0] data_read;
    int          req_count, overlap_count;

    step_t       steps [0:255];
    logic [7:0]  ref_bytes [0:prom_start-1];   // Expected ROM contents by byte address
    int          n_steps;
    int          errors;
    int          seed;

    game_rom #(
        .snd_offset(snd_offset), .char_offset(char_offset), .prom_start(prom_start),
        .main_aw(17), .snd_aw(15), .char_aw(12)
    ) DUT (.*);

    sdram_model u_sdram (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("error %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic check_quiet(input string when);
        if (sdram_req !== 1'b0) report_mismatch($sformatf("sdram_req %s", when), 0, sdram_req);
        if (main_ok !== 1'b0) report_mismatch($sformatf("main_ok %s", when), 0, main_ok);
        if (snd_ok !== 1'b0) report_mismatch($sformatf("snd_ok %s", when), 0, snd_ok);
        if (char_ok !== 1'b0) report_mismatch($sformatf("char_ok %s", when), 0, char_ok);
        if (rom_ready !== 1'b0) report_mismatch($sformatf("rom_ready %s", when), 0, rom_ready);
    endtask

    task automatic add_load(input logic [21:0] addr);
        step_t s;
        s      = '0;
        s.addr = addr;
        s.data = $random(seed);
        if (addr < prom_start) ref_bytes[addr] = s.data;
        steps[n_steps] = s;
        n_steps++;
    endtask

    task automatic add_read(input logic [2:0] clients, input logic hit, input int ma,
                            input int sa, input int ca);
        step_t s;
        s           = '0;
        s.read      = 1'b1;
        s.hit       = hit;
        s.clients   = clients;
        s.main_addr = ma;
        s.snd_addr  = sa;
        s.char_addr = ca;
        s.main_exp  = ref_bytes[ma];
        s.snd_exp   = ref_bytes[snd_base + sa];
        // Even byte sits in the low half
        s.char_exp  = {ref_bytes[char_base + 2 * ca + 1], ref_bytes[char_base + 2 * ca]};
        steps[n_steps] = s;
        n_steps++;
    endtask

    function automatic int pick_addr(input int upper, input int span);
        int a;
        a = {$random(seed)} % span;
        if ($random(seed) & 1) a = a + upper;
        return a;
    endfunction

    task automatic build_steps();
        for (int i = 0; i < 32; i++) begin
            add_load(i);    // Two blocks per region at its start and its end
            add_load('h13FE0 + i);
            add_load(snd_base + i);
            add_load(snd_base + 'h3FE0 + i);
            add_load(char_base + i);
            add_load(char_base + 'h1FE0 + i);
        end
        add_load(prom_start + 'h010);
        add_load(prom_start + 'h1A5);
        add_load(prom_start + 'h2FF);
        add_load(prom_start + 'h300);
        add_read(3'b001, 1'b0, 'h00005, 0, 0);
        add_read(3'b001, 1'b1, 'h00006, 0, 0);  // Same 32-bit word
        add_read(3'b001, 1'b0, 'h13FE9, 0, 0);
        add_read(3'b001, 1'b1, 'h13FEB, 0, 0);
        add_read(3'b010, 1'b0, 0, 'h0002, 0);
        add_read(3'b010, 1'b1, 0, 'h0001, 0);
        add_read(3'b010, 1'b0, 0, 'h3FE4, 0);
        add_read(3'b100, 1'b0, 0, 0, 'h000);
        add_read(3'b100, 1'b1, 0, 0, 'h001);
        add_read(3'b100, 1'b0, 0, 0, 'hFF3);
        for (int i = 0; i < 16; i++) begin
            add_read(3'b111, 1'b0, pick_addr('h13FE0, 32), pick_addr('h3FE0, 32),
                     pick_addr('hFF0, 16));
        end
    endtask

    task automatic apply_load(input step_t s);
        logic [3:0] exp_prom;
        logic [1:0] exp_mask;
        exp_mask = (s.addr % 2 == 0) ? 2'b10 : 2'b01;   // Even byte keeps the high lane
        @(posedge clk);
        ioctl_wr   <= 1'b1;
        ioctl_addr <= s.addr;
        ioctl_data <= s.data;
        @(negedge clk);
        check_quiet("during the download");
        if (prog_we !== 1'b0) report_mismatch("prog_we before the write", 0, prog_we);
        if (prom_we !== 4'd0) report_mismatch("prom_we before the write", 0, prom_we);
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(negedge clk);
        check_quiet("during the download");
        if (s.addr >= prom_start) begin
            exp_prom = 4'b0001 << ((s.addr - prom_start) >> 8);
            if (prom_we !== exp_prom) report_mismatch("prom strobe", exp_prom, prom_we);
            if (prog_we !== 1'b0) report_mismatch("prog_we on prom byte", 0, prog_we);
        end else begin
            if (prog_we !== 1'b1) report_mismatch("prog_we", 1, prog_we);
            if (prog_addr !== s.addr >> 1) report_mismatch("prog_addr", s.addr >> 1, prog_addr);
            if (prog_data !== s.data) report_mismatch("prog_data", s.data, prog_data);
            if (prog_mask !== exp_mask) report_mismatch("prog_mask", exp_mask, prog_mask);
            if (prom_we !== 4'd0) report_mismatch("prom_we on program byte", 0, prom_we);
        end
    endtask

    task automatic apply_read(input step_t s);
        logic [2:0] pending;
        int         start_count;
        int         waited;
        start_count = req_count;
        pending     = s.clients;
        waited      = 0;
        @(posedge clk);
        main_cs   <= s.clients[0];
        main_addr <= s.main_addr;
        snd_cs    <= s.clients[1];
        snd_addr  <= s.snd_addr;
        char_cs   <= s.clients[2];
        char_addr <= s.char_addr;
        while (pending != 3'b000) begin
            @(negedge clk);
            waited++;
            if (pending[0] && main_ok === 1'b1) begin
                if (main_dout !== s.main_exp) begin
                    report_mismatch($sformatf("main read %h", s.main_addr), s.main_exp, main_dout);
                end
                pending[0] = 1'b0;
            end
            if (pending[1] && snd_ok === 1'b1) begin
                if (snd_dout !== s.snd_exp) begin
                    report_mismatch($sformatf("sound read %h", s.snd_addr), s.snd_exp, snd_dout);
                end
                pending[1] = 1'b0;
            end
            if (pending[2] && char_ok === 1'b1) begin
                if (char_dout !== s.char_exp) begin
                    report_mismatch($sformatf("char read %h", s.char_addr), s.char_exp, char_dout);
                end
                pending[2] = 1'b0;
            end
        end
        @(posedge clk);
        main_cs <= 1'b0;
        snd_cs  <= 1'b0;
        char_cs <= 1'b0;
        @(negedge clk);
        if (main_ok !== 1'b0) report_mismatch("main_ok after cs fell", 0, main_ok);
        if (snd_ok !== 1'b0) report_mismatch("snd_ok after cs fell", 0, snd_ok);
        if (char_ok !== 1'b0) report_mismatch("char_ok after cs fell", 0, char_ok);
        if (s.hit && (waited != 1 || req_count != start_count || sdram_req !== 1'b0)) begin
            errors++;
            $display("a read inside the cached word did not give ok at once from the slot");
        end
    endtask

    initial begin
        seed        = 73;
        errors      = 0;
        n_steps     = 0;
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        main_cs     = 1'b0;
        main_addr   = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        char_cs     = 1'b0;
        char_addr   = '0;
        build_steps();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_quiet("after reset");
        if (prog_we !== 1'b0) report_mismatch("prog_we after reset", 0, prog_we);
        if (prom_we !== 4'd0) report_mismatch("prom_we after reset", 0, prom_we);
        // Clients keep asking during the download and must get nothing
        @(posedge clk);
        downloading <= 1'b1;
        main_cs     <= 1'b1;
        snd_cs      <= 1'b1;
        char_cs     <= 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            if (steps[i].read && downloading) begin
                @(posedge clk);
                downloading <= 1'b0;
                main_cs     <= 1'b0;
                snd_cs      <= 1'b0;
                char_cs     <= 1'b0;
                @(negedge clk);
                check_quiet("in the cycle downloading falls");
                @(posedge clk);
                @(negedge clk);
                if (rom_ready !== 1'b1) begin
                    report_mismatch("rom_ready after the download", 1, rom_ready);
                end
            end
            if (steps[i].read) begin
                apply_read(steps[i]);
            end else begin
                apply_load(steps[i]);
            end
        end
        @(posedge clk);
        $display("%0d check errors, %0d SDRAM overlap errors", errors, overlap_count);
        if (errors == 0 && overlap_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog scaled by the number of rows
    initial begin
        @(negedge reset);   // Table is complete by then
        repeat (n_steps * 40) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", n_steps * 40);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* testbench/sdram_model.sv */
`timescale 1ns/1ns

module sdram_model (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         sdram_req,
    input  logic [rom_pkg::sdram_aw-1:0] sdram_addr,
    output logic                         sdram_ack,
    output logic                         data_rdy,
    output logic [rom_pkg::sdram_dw-1:0] data_read,
    input  logic                         prog_we,
    input  logic [rom_pkg::sdram_aw-1:0] prog_addr,
    input  logic [7:0]                   prog_data,
    input  logic [1:0]                   prog_mask,
    output int                           req_count,
    output int                           overlap_count
);

    logic [15:0] mem [0:65535];     // Covers every ROM region
    logic [15:0] word_addr;
    int          seed;
    int          delay;

    // Program writes, a set mask bit keeps that byte
    always @(posedge clk) begin
        if (prog_we) begin
            if (!prog_mask[0]) mem[prog_addr[15:0]][7:0] <= prog_data;
            if (!prog_mask[1]) mem[prog_addr[15:0]][15:8] <= prog_data;
        end
    end

    initial begin
        seed          = 73;
        sdram_ack     = 1'b0;
        data_rdy      = 1'b0;
        data_read     = '0;
        req_count     = 0;
        overlap_count = 0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i ^ 16'hC35A;  // Unloaded words still differ by address
        end
        forever begin
            @(posedge clk);
            if (sdram_req === 1'b1 && !reset) begin
                req_count = req_count + 1;
                word_addr = sdram_addr[15:0];
                delay     = 1 + {$random(seed)} % 6;    // Acknowledge latency
                repeat (delay - 1) @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                delay = 1 + {$random(seed)} % 6;        // Data latency
                for (int i = 0; i <= delay; i++) begin
                    @(posedge clk);
                    if (sdram_req === 1'b1) begin
                        overlap_count = overlap_count + 1;
                        $display("SDRAM model got a second request before data_rdy");
                    end
                    data_rdy  <= (i == delay - 1);
                    data_read <= {mem[word_addr + 16'd1], mem[word_addr]};
                end
            end
        end
    end

endmodule

/* vlog.f */
source/rom_pkg.sv
source/prom_loader.sv
source/rom_slot.sv
source/rom_arbiter.sv
source/game_rom.sv
testbench/sdram_model.sv
testbench/game_rom_tb.sv
